/* sources.f */
+incdir+source
+incdir+sim
source/fc_irq_pkg.sv
source/fc_evt_fifo.sv
source/fc_irq_pending.sv
source/fc_irq_lines.sv
source/fc_irq_top.sv
sim/fc_irq_tb.sv

/* sim/fc_irq_tb_ref.svh */
// Reference model and compare tasks, included inside fc_irq_tb.
// Needs the fc_irq_pkg types and the check counters declared before it.

`ifndef FC_IRQ_TB_REF_SVH
`define FC_IRQ_TB_REF_SVH

// Next state of the stimulus LCG
function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
endfunction

//************************************************************
//****** Reference model *************************************
//************************************************************

// Expected lines: highest pending line, FIFO line live while entries remain
function automatic irq_vec_t expected_irq(input irq_vec_t pend, input int unsigned fifo_cnt);
    irq_vec_t live;
    irq_vec_t onehot;
    live = pend;
    live[`FC_EVT_FIFO_IRQ] = (fifo_cnt != 0);
    onehot = '0;
    for (int k = `FC_NUM_IRQ - 1; k >= 0; k--) begin
        if (live[k] && (onehot == '0)) begin
            onehot[k] = 1'b1;
        end
    end
    return onehot;
endfunction

// Line number of a one-hot vector
function automatic irq_id_t onehot_to_id(input irq_vec_t vec);
    irq_id_t id;
    id = '0;
    for (int k = 0; k < `FC_NUM_IRQ; k++) begin
        if (vec[k]) begin
            id = irq_id_t'(k);
        end
    end
    return id;
endfunction

//************************************************************
//****** Compare tasks ***************************************
//************************************************************

task automatic check_vec(input string name, input irq_vec_t exp, input irq_vec_t act);
    n_checks++;
    if (act !== exp) begin
        n_errors++;
        $display("Fail at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
endtask

task automatic check_id(input string name, input evt_id_t exp, input evt_id_t act);
    n_checks++;
    if (act !== exp) begin
        n_errors++;
        $display("Fail at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
    n_checks++;
    if (act !== exp) begin
        n_errors++;
        $display("Fail at %0t: %s expected %b, got %b", $time, name, exp, act);
    end
endtask

`endif

/* sim/fc_irq_tb.sv */
// Testbench of the interrupt path. Inputs change 1 ns after the rising edge.
// A model of pending lines and FIFO contents predicts each served line.

`timescale 1ns/100ps

`include "fc_irq_cfg.svh"

module fc_irq_tb import fc_irq_pkg::*; ();

    localparam int          WAIT_LIMIT  = 20;
    localparam int          SERVE_LIMIT = 4000;
    localparam logic [31:0] LCG_SEED    = 32'h448f_2dee;

    logic     clk_i;
    logic     rst_n_i;
    irq_vec_t events_i;
    logic     event_fifo_valid_i;
    evt_id_t  event_fifo_data_i;
    logic     event_fifo_fulln_o;
    evt_id_t  evt_id_o;
    logic     core_irq_ack_i;
    irq_id_t  core_irq_ack_id_i;
    irq_vec_t core_irq_x_o;

    int          n_checks;
    int          n_errors;
    int          n_tests;
    int          served_cnt;
    logic        serve_go;
    logic        stalled;
    irq_vec_t    model_pend;
    evt_id_t     model_fifo[$];
    logic [31:0] lcg_state;

    `include "fc_irq_tb_ref.svh"

    fc_irq_top dut0 (
        .clk_i              ( clk_i              ),
        .rst_n_i            ( rst_n_i            ),
        .events_i           ( events_i           ),
        .event_fifo_valid_i ( event_fifo_valid_i ),
        .event_fifo_data_i  ( event_fifo_data_i  ),
        .event_fifo_fulln_o ( event_fifo_fulln_o ),
        .evt_id_o           ( evt_id_o           ),
        .core_irq_ack_i     ( core_irq_ack_i     ),
        .core_irq_ack_id_i  ( core_irq_ack_id_i  ),
        .core_irq_x_o       ( core_irq_x_o       )
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    //************************************************************
    //****** Stimulus helpers ************************************
    //************************************************************

    task automatic tick();
        @(posedge clk_i);
        #1;
    endtask

    // One-cycle event pulse
    // Line 26 of events_i is not modelled
    task automatic pulse_events(input irq_vec_t vec);
        events_i   = vec;
        model_pend = model_pend | vec;
        model_pend[`FC_EVT_FIFO_IRQ] = 1'b0;
        tick();
        events_i = '0;
    endtask

    task automatic push_id(input evt_id_t id);
        event_fifo_valid_i = 1'b1;
        event_fifo_data_i  = id;
        if (model_fifo.size() < `FC_EVT_FIFO_DEPTH) begin
            model_fifo.push_back(id);
        end
        tick();
        event_fifo_valid_i = 1'b0;
    endtask

    // Waits for a raised line, checks it, acknowledges it
    task automatic serve_one();
        irq_vec_t exp_vec;
        irq_id_t  id;
        int       waited;
        waited = 0;
        while ((core_irq_x_o == '0) && (waited < WAIT_LIMIT)) begin
            tick();
            waited++;
        end
        if (core_irq_x_o == '0) begin
            $display("Timeout at %0t: no interrupt line raised while work is pending", $time);
            n_errors++;
            stalled = 1'b1;
        end else begin
            exp_vec = expected_irq(model_pend, model_fifo.size());
            check_vec("core_irq_x_o", exp_vec, core_irq_x_o);
            id = onehot_to_id(exp_vec);
            if (id == irq_id_t'(`FC_EVT_FIFO_IRQ)) begin
                check_id("evt_id_o", model_fifo[0], evt_id_o);
                void'(model_fifo.pop_front());
            end else begin
                model_pend[id] = 1'b0;
            end
            core_irq_ack_i    = 1'b1;
            core_irq_ack_id_i = id;
            tick();
            core_irq_ack_i = 1'b0;
            // Stale selection must be hidden by now
            tick();
            check_vec("core_irq_x_o", '0, core_irq_x_o);
            served_cnt++;
        end
    endtask

    // Compare process that serves the model on request
    initial begin : compare_proc
        forever begin
            @(negedge clk_i);
            if (serve_go) begin
                tick();
                while (!stalled && ((model_pend != '0) || (model_fifo.size() != 0))) begin
                    serve_one();
                end
                // Second cycle of suppression after the last acknowledge
                tick();
                check_vec("core_irq_x_o", '0, core_irq_x_o);
                serve_go = 1'b0;
            end
        end
    end

    task automatic serve_and_wait(input int exp_served);
        int waited;
        waited     = 0;
        served_cnt = 0;
        serve_go   = 1'b1;
        while (serve_go && (waited < SERVE_LIMIT)) begin
            @(negedge clk_i);
            waited++;
        end
        if (serve_go) begin
            $display("Timeout at %0t: serving of pending lines did not finish", $time);
            n_errors++;
            stalled = 1'b1;
        end else if (served_cnt != exp_served) begin
            n_errors++;
            $display("Fail at %0t: served_cnt expected %0d, got %0d",
                     $time, exp_served, served_cnt);
        end
        tick();
    endtask

    task automatic check_quiet();
        repeat (4) tick();
        check_vec("core_irq_x_o", '0, core_irq_x_o);
    endtask

    task automatic report_test(input string name, input int err_mark);
        n_tests++;
        if (n_errors == err_mark) begin
            $display("test %0d %s: ok", n_tests, name);
        end else begin
            $display("test %0d %s: %0d mismatches", n_tests, name, n_errors - err_mark);
        end
    endtask

    //************************************************************
    //****** Test sequence ***************************************
    //************************************************************

    initial begin : test_seq
        irq_vec_t rand_ev;
        irq_id_t  rand_line;
        int       err_mark;
        n_checks           = 0;
        n_errors           = 0;
        n_tests            = 0;
        served_cnt         = 0;
        serve_go           = 1'b0;
        stalled            = 1'b0;
        model_pend         = '0;
        rst_n_i            = 1'b0;
        events_i           = '0;
        event_fifo_valid_i = 1'b0;
        event_fifo_data_i  = '0;
        core_irq_ack_i     = 1'b0;
        core_irq_ack_id_i  = '0;
        repeat (2) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        tick();

        err_mark = n_errors;
        check_vec("core_irq_x_o", '0, core_irq_x_o);
        check_bit("event_fifo_fulln_o", 1'b1, event_fifo_fulln_o);
        check_id("evt_id_o", '0, evt_id_o);
        report_test("reset state", err_mark);

        // Fixed latency of two cycles after the sampling edge
        err_mark = n_errors;
        pulse_events(irq_vec_t'(1) << 5);
        check_vec("core_irq_x_o", '0, core_irq_x_o);
        tick();
        check_vec("core_irq_x_o", '0, core_irq_x_o);
        tick();
        check_vec("core_irq_x_o", expected_irq(model_pend, 0), core_irq_x_o);
        repeat (3) tick();
        check_vec("core_irq_x_o", expected_irq(model_pend, 0), core_irq_x_o);
        serve_and_wait(1);
        check_quiet();
        report_test("single line latency", err_mark);

        err_mark = n_errors;
        pulse_events((irq_vec_t'(1) << 3) | (irq_vec_t'(1) << 17));
        serve_and_wait(2);
        check_quiet();
        report_test("two lines by priority", err_mark);

        err_mark = n_errors;
        push_id(8'h3c);
        push_id(8'ha5);
        push_id(8'h71);
        serve_and_wait(3);
        check_quiet();
        check_id("evt_id_o", '0, evt_id_o);
        report_test("event FIFO order", err_mark);

        err_mark = n_errors;
        push_id(8'h11);
        push_id(8'h22);
        push_id(8'h33);
        push_id(8'h44);
        check_bit("event_fifo_fulln_o", 1'b0, event_fifo_fulln_o);
        push_id(8'hee);
        check_bit("event_fifo_fulln_o", 1'b0, event_fifo_fulln_o);
        serve_and_wait(4);
        check_quiet();
        check_bit("event_fifo_fulln_o", 1'b1, event_fifo_fulln_o);
        report_test("push while full", err_mark);

        // Random pulses and pushes, then everything is served
        err_mark  = n_errors;
        lcg_state = LCG_SEED;
        for (int cyc = 0; cyc < 24; cyc++) begin
            lcg_state = lcg_next(lcg_state);
            rand_ev   = '0;
            rand_line = lcg_state[20:16];
            if (lcg_state[31] && (rand_line != irq_id_t'(`FC_EVT_FIFO_IRQ))) begin
                rand_ev[rand_line] = 1'b1;
            end
            check_bit("event_fifo_fulln_o", model_fifo.size() < `FC_EVT_FIFO_DEPTH,
                      event_fifo_fulln_o);
            events_i           = rand_ev;
            model_pend         = model_pend | rand_ev;
            event_fifo_data_i  = lcg_state[27:20];
            event_fifo_valid_i = lcg_state[9] & lcg_state[5] &
                                 (model_fifo.size() < `FC_EVT_FIFO_DEPTH);
            if (event_fifo_valid_i) begin
                model_fifo.push_back(event_fifo_data_i);
            end
            tick();
        end
        events_i           = '0;
        event_fifo_valid_i = 1'b0;
        repeat (4) tick();
        serve_and_wait($countones(model_pend) + model_fifo.size());
        check_quiet();
        report_test("random events", err_mark);

        $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* source/fc_irq_top.sv */
// Interrupt path top: event FIFO, pending/select, line driver.
// Acknowledge must name the line that is currently raised.

`timescale 1ns/100ps

`include "fc_irq_cfg.svh"

module fc_irq_top import fc_irq_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_n_i,

    // Direct event lines and event FIFO
    input  irq_vec_t events_i,
    input  logic     event_fifo_valid_i,
    input  evt_id_t  event_fifo_data_i,
    output logic     event_fifo_fulln_o,
    output evt_id_t  evt_id_o,

    // Core side
    input  logic     core_irq_ack_i,
    input  irq_id_t  core_irq_ack_id_i,
    output irq_vec_t core_irq_x_o
);

    logic    evt_nempty;
    logic    fifo_pop;
    logic    ack_pulse;
    irq_id_t ack_id;
    logic    sel_req;
    irq_id_t sel_id;

    //************************************************************
    //****** Input, processing and output stages *****************
    //************************************************************

    fc_evt_fifo i_evt_fifo (
        .clk_i              ( clk_i              ),
        .rst_n_i            ( rst_n_i            ),
        .event_fifo_valid_i ( event_fifo_valid_i ),
        .event_fifo_data_i  ( event_fifo_data_i  ),
        .fifo_pop_i         ( fifo_pop           ),
        .event_fifo_fulln_o ( event_fifo_fulln_o ),
        .evt_id_o           ( evt_id_o           ),
        .evt_nempty_o       ( evt_nempty         )
    );

    fc_irq_pending i_irq_pending (
        .clk_i        ( clk_i      ),
        .rst_n_i      ( rst_n_i    ),
        .events_i     ( events_i   ),
        .evt_nempty_i ( evt_nempty ),
        .ack_pulse_i  ( ack_pulse  ),
        .ack_id_i     ( ack_id     ),
        .sel_req_o    ( sel_req    ),
        .sel_id_o     ( sel_id     )
    );

    fc_irq_lines i_irq_lines (
        .clk_i             ( clk_i             ),
        .rst_n_i           ( rst_n_i           ),
        .sel_req_i         ( sel_req           ),
        .sel_id_i          ( sel_id            ),
        .core_irq_ack_i    ( core_irq_ack_i    ),
        .core_irq_ack_id_i ( core_irq_ack_id_i ),
        .ack_pulse_o       ( ack_pulse         ),
        .ack_id_o          ( ack_id            ),
        .fifo_pop_o        ( fifo_pop          ),
        .core_irq_x_o      ( core_irq_x_o      )
    );

endmodule

/* source/fc_irq_lines.sv */
// Drives the one-hot lines to the core and decodes its acknowledge.
// An acknowledged line is held low for two cycles to hide stale selections.

`timescale 1ns/100ps

`include "fc_irq_cfg.svh"

module fc_irq_lines import fc_irq_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_n_i,

    input  logic     sel_req_i,
    input  irq_id_t  sel_id_i,

    input  logic     core_irq_ack_i,
    input  irq_id_t  core_irq_ack_id_i,

    output logic     ack_pulse_o,
    output irq_id_t  ack_id_o,
    output logic     fifo_pop_o,
    output irq_vec_t core_irq_x_o
);

    // Two-stage history of acknowledged IDs
    logic [1:0] supp_vld_q;
    irq_id_t    supp_id_q [2];

    irq_vec_t   sel_vec;
    irq_vec_t   supp_vec;
    irq_vec_t   irq_x_q;

    //************************************************************
    //****** Acknowledge from the core ***************************
    //************************************************************

    assign ack_pulse_o = core_irq_ack_i;
    assign ack_id_o    = core_irq_ack_id_i;

    // Serving the FIFO line consumes one FIFO entry
    assign fifo_pop_o = core_irq_ack_i &&
                        (core_irq_ack_id_i == irq_id_t'(`FC_EVT_FIFO_IRQ));

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            supp_vld_q   <= '0;
            supp_id_q[0] <= '0;
            supp_id_q[1] <= '0;
        end else begin
            supp_vld_q   <= {supp_vld_q[0], core_irq_ack_i};
            supp_id_q[0] <= core_irq_ack_id_i;
            supp_id_q[1] <= supp_id_q[0];
        end
    end

    //************************************************************
    //****** Line vector *****************************************
    //************************************************************

    always_comb begin
        sel_vec  = '0;
        supp_vec = '0;
        if (sel_req_i) begin
            sel_vec[sel_id_i] = 1'b1;
        end
        if (supp_vld_q[0]) begin
            supp_vec[supp_id_q[0]] = 1'b1;
        end
        if (supp_vld_q[1]) begin
            supp_vec[supp_id_q[1]] = 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            irq_x_q <= '0;
        end else begin
            irq_x_q <= sel_vec & ~supp_vec;
        end
    end

    assign core_irq_x_o = irq_x_q;

endmodule

/* source/fc_irq_pending.sv */
// Pending register and registered priority select, highest line wins.
// The FIFO line mirrors the FIFO level and ignores its events_i bit.

`timescale 1ns/100ps

`include "fc_irq_cfg.svh"

module fc_irq_pending import fc_irq_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_n_i,

    input  irq_vec_t events_i,
    input  logic     evt_nempty_i,

    input  logic     ack_pulse_i,
    input  irq_id_t  ack_id_i,

    output logic     sel_req_o,
    output irq_id_t  sel_id_o
);

    irq_vec_t pending_q;
    irq_vec_t pending_d;
    irq_vec_t ack_vec;

    logic     sel_req_d;
    irq_id_t  sel_id_d;
    logic     sel_req_q;
    irq_id_t  sel_id_q;

    //************************************************************
    //****** Acknowledge decode **********************************
    //************************************************************

    // One-hot of the acknowledged line, empty without a pulse
    always_comb begin
        ack_vec = '0;
        if (ack_pulse_i) begin
            ack_vec[ack_id_i] = 1'b1;
        end
    end

    //************************************************************
    //****** Pending bits ****************************************
    //************************************************************

    always_comb begin
        // A new event beats the clear in the same cycle
        pending_d = events_i | (pending_q & ~ack_vec);

        // Line of the event FIFO just tracks the fill state
        pending_d[`FC_EVT_FIFO_IRQ] = evt_nempty_i;
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pending_q <= '0;
        end else begin
            pending_q <= pending_d;
        end
    end

    //************************************************************
    //****** Priority select *************************************
    //************************************************************

    // Upward scan, so the last hit is the highest pending line
    always_comb begin
        sel_req_d = 1'b0;
        sel_id_d  = '0;
        for (int k = 0; k < `FC_NUM_IRQ; k++) begin
            if (pending_q[k]) begin
                sel_req_d = 1'b1;
                sel_id_d  = irq_id_t'(k);
            end
        end
    end

    // Selection is registered, one cycle behind the pending bits
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sel_req_q <= 1'b0;
            sel_id_q  <= '0;
        end else begin
            sel_req_q <= sel_req_d;
            sel_id_q  <= sel_id_d;
        end
    end

    assign sel_req_o = sel_req_q;
    assign sel_id_o  = sel_id_q;

endmodule

/* source/fc_evt_fifo.sv */
// Event-ID FIFO. A push while full is dropped, so the source must watch fulln.
// A pop on an empty FIFO is ignored.

`timescale 1ns/100ps

`include "fc_irq_cfg.svh"

module fc_evt_fifo import fc_irq_pkg::*; (
    input  logic    clk_i,
    input  logic    rst_n_i,

    input  logic    event_fifo_valid_i,
    input  evt_id_t event_fifo_data_i,
    input  logic    fifo_pop_i,

    output logic    event_fifo_fulln_o,
    output evt_id_t evt_id_o,
    output logic    evt_nempty_o
);

    localparam int PTR_W = $clog2(`FC_EVT_FIFO_DEPTH);
    localparam int CNT_W = $clog2(`FC_EVT_FIFO_DEPTH + 1);

    // Storage, payload only
    evt_id_t             fifo_mem [`FC_EVT_FIFO_DEPTH];

    logic [PTR_W-1:0]    wr_ptr_q;
    logic [PTR_W-1:0]    rd_ptr_q;
    logic [CNT_W-1:0]    count_q;

    logic                full;
    logic                empty;
    logic                do_push;
    logic                do_pop;

    assign full  = (count_q == CNT_W'(`FC_EVT_FIFO_DEPTH));
    assign empty = (count_q == '0);

    // Push only with room left, pop only with data present
    assign do_push = event_fifo_valid_i & ~full;
    assign do_pop  = fifo_pop_i & ~empty;

    //************************************************************
    //****** Pointers and fill level *****************************
    //************************************************************

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                if (wr_ptr_q == PTR_W'(`FC_EVT_FIFO_DEPTH - 1)) begin
                    wr_ptr_q <= '0;
                end else begin
                    wr_ptr_q <= wr_ptr_q + 1'b1;
                end
            end

            if (do_pop) begin
                if (rd_ptr_q == PTR_W'(`FC_EVT_FIFO_DEPTH - 1)) begin
                    rd_ptr_q <= '0;
                end else begin
                    rd_ptr_q <= rd_ptr_q + 1'b1;
                end
            end

            // Push and pop together leave the level unchanged
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Write port
    always_ff @(posedge clk_i) begin
        if (do_push) begin
            fifo_mem[wr_ptr_q] <= event_fifo_data_i;
        end
    end

    //************************************************************
    //****** Outputs *********************************************
    //************************************************************

    assign event_fifo_fulln_o = ~full;
    assign evt_nempty_o       = ~empty;

    // Head entry, zero while nothing is stored
    assign evt_id_o = empty ? '0 : fifo_mem[rd_ptr_q];

endmodule

/* source/fc_irq_pkg.sv */
// Shared vector and ID types of the interrupt path.
// Widths come from the cfg header.

`include "fc_irq_cfg.svh"

package fc_irq_pkg;

    //************************************************************
    //****** Interrupt path types ********************************
    //************************************************************

    // One bit per interrupt line, bit k is line k
    typedef logic [`FC_NUM_IRQ-1:0] irq_vec_t;

    // Interrupt number, used by selection and acknowledge
    typedef logic [`FC_IRQ_ID_W-1:0] irq_id_t;

    // Event ID as pushed into the event FIFO
    typedef logic [`FC_EVT_ID_W-1:0] evt_id_t;

endpackage

/* source/fc_irq_cfg.svh */
// Sizes of the interrupt path. The FIFO line must stay below FC_NUM_IRQ
// and FC_IRQ_ID_W must be wide enough to number every line.

`ifndef FC_IRQ_CFG_SVH
`define FC_IRQ_CFG_SVH

// Number of interrupt lines towards the core
`define FC_NUM_IRQ 32

// Width of an interrupt number
`define FC_IRQ_ID_W 5

// Width of an event ID held in the FIFO
`define FC_EVT_ID_W 8

// Entries in the event FIFO
`define FC_EVT_FIFO_DEPTH 4

// Line that is pending while the FIFO holds anything
`define FC_EVT_FIFO_IRQ 26

`endif
